//--- all.f
+incdir+include
rtl/fft_pe_pkg.sv
rtl/inst_rom.sv
rtl/twiddle_rom.sv
rtl/reg_file.sv
rtl/complex_alu.sv
rtl/pe.sv
rtl/fft4_pipe.sv
verif/fft4_pipe_tb.sv

//--- verif/fft4_pipe_tb.sv
`include "fft_pe_defines.svh"

module fft4_pipe_tb;
   import fft_pe_pkg::*;

   localparam int N_DIR      = 7;              // directed rows
   localparam int N_RAND     = 20;
   localparam int N_ROWS     = N_DIR + N_RAND;
   localparam int RST_CYCLES = 4;
   localparam int MAX_MAG    = 4095;           // input part bound

   logic  clk;
   logic  rst;
   logic  din_v;
   cplx_t din;
   logic  dout_v;
   cplx_t dout;

   string row_name [N_ROWS];
   cplx_t row_in   [N_ROWS][`LOAD_NUM];        // x0..x3
   cplx_t row_exp  [N_ROWS][`OUT_NUM];         // X0..X3

   cplx_t out_q [$];                           // dout words in arrival order
   int    len_q [$];                           // length of each dout_v run
   int    run_len = 0;
   int    n_tests;
   int    n_failed;
   int    n_errors;

   fft4_pipe dut_i (
      .clk    (clk),
      .rst    (rst),
      .din_v  (din_v),
      .din    (din),
      .dout_v (dout_v),
      .dout   (dout)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////////////////////////
   // output monitor
   ////////////////////////////////////////
   always @(posedge clk) begin
      if (dout_v === 1'b1) begin
         out_q.push_back(dout);
         run_len++;
      end else if (run_len != 0) begin   // burst just ended
         len_q.push_back(run_len);
         run_len = 0;
      end
   end

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////
   function automatic cplx_t cplx(int re, int im);
      return {re[`DATA_WIDTH-1:0], im[`DATA_WIDTH-1:0]};
   endfunction

   // Xk = sum of xn * (-j)^(n*k), exact in integers
   function automatic cplx_t dft_point(int idx, int k);
      int acc_re;
      int acc_im;
      int xr;
      int xi;
      acc_re = 0;
      acc_im = 0;
      for (int n = 0; n < `LOAD_NUM; n++) begin
         xr = $signed(row_in[idx][n][`WORD_WIDTH-1 -: `DATA_WIDTH]);
         xi = $signed(row_in[idx][n][`DATA_WIDTH-1:0]);
         case ((n * k) % 4)
            0: begin
               acc_re += xr;
               acc_im += xi;
            end
            1: begin   // times -j
               acc_re += xi;
               acc_im -= xr;
            end
            2: begin
               acc_re -= xr;
               acc_im -= xi;
            end
            default: begin   // times +j
               acc_re -= xi;
               acc_im += xr;
            end
         endcase
      end
      return cplx(acc_re, acc_im);
   endfunction

   function automatic int rand_part();
      return int'($urandom_range(2 * MAX_MAG, 0)) - MAX_MAG;
   endfunction

   ////////////////////////////////////////
   // stimulus table
   ////////////////////////////////////////
   task automatic set_row(int idx, string name, cplx_t x0, cplx_t x1, cplx_t x2, cplx_t x3,
                          cplx_t e0, cplx_t e1, cplx_t e2, cplx_t e3);
      row_name[idx] = name;
      row_in[idx]   = '{x0, x1, x2, x3};
      row_exp[idx]  = '{e0, e1, e2, e3};
   endtask

   task automatic load_table();
      set_row(0, "impulse", cplx(1000, 0), cplx(0, 0), cplx(0, 0), cplx(0, 0),
              cplx(1000, 0), cplx(1000, 0), cplx(1000, 0), cplx(1000, 0));
      set_row(1, "dc", cplx(100, 0), cplx(100, 0), cplx(100, 0), cplx(100, 0),
              cplx(400, 0), cplx(0, 0), cplx(0, 0), cplx(0, 0));
      set_row(2, "alternating", cplx(500, 0), cplx(-500, 0), cplx(500, 0), cplx(-500, 0),
              cplx(0, 0), cplx(0, 0), cplx(2000, 0), cplx(0, 0));
      set_row(3, "pure_imag", cplx(0, 100), cplx(0, 200), cplx(0, 300), cplx(0, 400),
              cplx(0, 1000), cplx(-200, -200), cplx(0, -200), cplx(200, -200));
      set_row(4, "bound_pos_neg", cplx(4095, -4095), cplx(4095, -4095), cplx(4095, -4095),
              cplx(4095, -4095), cplx(16380, -16380), cplx(0, 0), cplx(0, 0), cplx(0, 0));
      set_row(5, "bound_alt", cplx(4095, 4095), cplx(-4095, -4095), cplx(4095, 4095),
              cplx(-4095, -4095), cplx(0, 0), cplx(0, 0), cplx(16380, 16380), cplx(0, 0));
      set_row(6, "mixed_sign", cplx(10, -20), cplx(-30, 40), cplx(50, 60), cplx(-70, -80),
              cplx(-40, 0), cplx(80, -120), cplx(160, 80), cplx(-160, -40));
      // random rows, expected values from the dft model
      for (int r = N_DIR; r < N_ROWS; r++) begin
         row_name[r] = $sformatf("rand_%0d", r - N_DIR);
         for (int n = 0; n < `LOAD_NUM; n++) begin
            row_in[r][n] = cplx(rand_part(), rand_part());
         end
         for (int k = 0; k < `OUT_NUM; k++) begin
            row_exp[r][k] = dft_point(r, k);
         end
      end
   endtask

   ////////////////////////////////////////
   // drive, wait, check
   ////////////////////////////////////////
   // n_words words on consecutive cycles, then din_v low, takes n_words+1 edges
   task automatic send_words(int idx, int n_words);
      for (int i = 0; i < n_words; i++) begin
         @(posedge clk);
         #10;
         din_v = 1'b1;
         din   = row_in[idx][i];
      end
      @(posedge clk);
      #10;
      din_v = 1'b0;
      din   = '0;
   endtask

   task automatic wait_words(string test, int n, int limit);
      int cyc;
      cyc = 0;
      while (out_q.size() < n && cyc < limit) begin
         @(posedge clk);
         cyc++;
      end
      if (out_q.size() < n) begin
         $display("test %s: timeout, only %0d of %0d output words after %0d cycles",
                  test, out_q.size(), n, cyc);
         n_errors++;
      end
   endtask

   task automatic check_row(string test, int idx);
      cplx_t got;
      int    bad;
      bad = 0;
      for (int k = 0; k < `OUT_NUM; k++) begin
         if (out_q.size() == 0) begin
            $display("test %s/%s: output X%0d never arrived", test, row_name[idx], k);
            bad++;
         end else begin
            got = out_q.pop_front();
            if (got !== row_exp[idx][k]) begin
               $display("MISMATCH %s/%s X%0d: expected %h, actual %h",
                        test, row_name[idx], k, row_exp[idx][k], got);
               bad++;
            end
         end
      end
      n_tests++;
      n_errors += bad;
      if (bad != 0) begin
         n_failed++;
         $display("row %s/%s: failed", test, row_name[idx]);
      end else begin
         $display("row %s/%s: ok", test, row_name[idx]);
      end
   endtask

   // blocks at BLOCK_SPACING plus up to jitter extra cycles
   task automatic run_blocks(string test, int first, int count, int jitter);
      int gap;
      int bad;
      out_q.delete();
      len_q.delete();
      for (int b = 0; b < count; b++) begin
         send_words(first + b, `LOAD_NUM);
         gap = `BLOCK_SPACING - `LOAD_NUM - 1;
         if (jitter > 0) begin
            gap += $urandom_range(jitter, 0);
         end
         repeat (gap) @(posedge clk);
      end
      wait_words(test, count * `OUT_NUM, 100 + 2 * count * `BLOCK_SPACING);
      repeat (2 * `BLOCK_SPACING) @(posedge clk);   // stray valids land here
      for (int b = 0; b < count; b++) begin
         check_row(test, first + b);
      end
      // burst shape, one run of OUT_NUM per block
      bad = 0;
      if (len_q.size() != count) begin
         $display("test %s: saw %0d output bursts for %0d input blocks",
                  test, len_q.size(), count);
         bad++;
      end
      foreach (len_q[i]) begin
         if (len_q[i] != `OUT_NUM) begin
            $display("test %s: burst %0d had %0d valid words instead of %0d",
                     test, i, len_q[i], `OUT_NUM);
            bad++;
         end
      end
      if (out_q.size() != 0) begin
         $display("test %s: %0d extra output words", test, out_q.size());
         bad++;
      end
      n_tests++;
      n_errors += bad;
      if (bad != 0) begin
         n_failed++;
         $display("bursts %s: failed", test);
      end else begin
         $display("bursts %s: ok", test);
      end
   endtask

   task automatic quiet_window(string test, int cycles);
      out_q.delete();
      len_q.delete();
      repeat (cycles) @(posedge clk);
      n_tests++;
      if (out_q.size() != 0 || run_len != 0) begin
         $display("test %s: dout_v was high for %0d cycles with no block due",
                  test, out_q.size());
         n_errors++;
         n_failed++;
      end else begin
         $display("quiet %s: ok", test);
      end
   endtask

   // partial or in-flight block, then reset, nothing may come out
   task automatic reset_mid_block(string test, int idx, int n_words, int hold);
      send_words(idx, n_words);
      repeat (hold) @(posedge clk);
      @(posedge clk);
      #10;
      rst = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      #10;
      rst = 1'b0;
      quiet_window(test, 3 * `BLOCK_SPACING);
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////
   initial begin
      void'($urandom(32'hfd53_3dae));
      rst      = 1'b1;
      din_v    = 1'b0;
      din      = '0;
      n_tests  = 0;
      n_failed = 0;
      n_errors = 0;
      load_table();
      repeat (RST_CYCLES) @(posedge clk);
      #10;
      rst = 1'b0;

      quiet_window("after_reset", 3 * `BLOCK_SPACING);
      for (int r = 0; r < N_DIR; r++) begin
         run_blocks(row_name[r], r, 1, 0);   // one block alone
      end
      run_blocks("pipelined", 0, N_DIR, 0);  // two blocks in flight
      run_blocks("random", N_DIR, N_RAND, 8);
      reset_mid_block("rst_mid_load", 6, 2, 0);
      run_blocks("after_rst_load", 6, 1, 0);
      reset_mid_block("rst_stage1_busy", 3, 4, 20);   // stage 1 in drain
      run_blocks("after_rst_busy", 5, 1, 0);

      $display("summary: %0d tests, %0d failed, %0d errors", n_tests, n_failed, n_errors);
      if (n_errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- rtl/fft4_pipe.sv
module fft4_pipe (
   input  logic              clk,
   input  logic              rst,
   input  logic              din_v,
   input  fft_pe_pkg::cplx_t din,
   output logic              dout_v,
   output fft_pe_pkg::cplx_t dout
);
   import fft_pe_pkg::*;

   logic  mid_v;   // stage 0 burst
   cplx_t mid;

   // stage 0, butterflies of span 2
   pe #(.STAGE(0)) pe0_i (
      .clk    (clk),
      .rst    (rst),
      .din_v  (din_v),
      .din    (din),
      .dout_v (mid_v),
      .dout   (mid)
   );

   // stage 1, span 1 with -j twiddle
   pe #(.STAGE(1)) pe1_i (
      .clk    (clk),
      .rst    (rst),
      .din_v  (mid_v),
      .din    (mid),
      .dout_v (dout_v),
      .dout   (dout)
   );

endmodule

//--- rtl/pe.sv
`include "fft_pe_defines.svh"

module pe #(
   parameter int STAGE = 0
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              din_v,
   input  fft_pe_pkg::cplx_t din,
   output logic              dout_v,
   output fft_pe_pkg::cplx_t dout
);
   import fft_pe_pkg::*;

   pe_state_e state;
   logic [$clog2(`LOAD_NUM)-1:0]  load_cnt;
   im_addr_t                      pc;          // also the compute count
   logic [$clog2(`ALU_LAT+2)-1:0] drain_cnt;
   logic [$clog2(`OUT_NUM)-1:0]   out_cnt;

   logic      ld_v;                            // delayed load write
   reg_addr_t ld_addr;
   cplx_t     ld_data;

   inst_t     inst;
   logic      fetch_v;                         // inst valid this cycle
   opcode_e   dec_op;
   tw_addr_t  dec_tw;
   reg_addr_t dec_rd, dec_ra, dec_rb;
   logic      issue_v;

   cplx_t     tw_data, rdata_a, rdata_b;
   logic      rf_re, rf_we;
   reg_addr_t raddr_a, out_addr, rf_waddr;
   cplx_t     rf_wdata;

   logic      alu_in_v;
   opcode_e   alu_op;
   reg_addr_t rd_pipe [`ALU_LAT+1];            // rd follows the alu
   logic      wb_v;
   cplx_t     wb_data;

   ////////////////////////////////////////
   // sequencing FSM
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= S_IDLE;
         load_cnt  <= '0;
         pc        <= '0;
         drain_cnt <= '0;
         out_cnt   <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (din_v) begin   // word 0 arrives
                  state    <= S_LOAD;
                  load_cnt <= load_cnt + 1'b1;
               end
            end
            S_LOAD: begin
               if (din_v) begin
                  if (load_cnt == `LOAD_NUM-1) begin
                     state    <= S_COMPUTE;
                     load_cnt <= '0;
                  end else begin
                     load_cnt <= load_cnt + 1'b1;
                  end
               end
            end
            S_COMPUTE: begin   // one issue per cycle
               if (pc == `INST_NUM-1) begin
                  state <= S_DRAIN;
                  pc    <= '0;
               end else begin
                  pc <= pc + 1'b1;
               end
            end
            S_DRAIN: begin   // last writeback lands here
               if (drain_cnt == `ALU_LAT+1) begin
                  state     <= S_OUTPUT;
                  drain_cnt <= '0;
               end else begin
                  drain_cnt <= drain_cnt + 1'b1;
               end
            end
            S_OUTPUT: begin
               if (out_cnt == `OUT_NUM-1) begin
                  state   <= S_IDLE;
                  out_cnt <= '0;
               end else begin
                  out_cnt <= out_cnt + 1'b1;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////
   // load capture, word n -> rn
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         ld_v <= 1'b0;
      end else begin
         ld_v <= din_v && (state == S_IDLE || state == S_LOAD);
      end
   end

   always_ff @(posedge clk) begin
      ld_addr <= reg_addr_t'(load_cnt);
      ld_data <= din;
   end

   ////////////////////////////////////////
   // fetch and decode
   ////////////////////////////////////////
   inst_rom #(.STAGE(STAGE)) inst_rom_i (
      .clk      (clk),
      .en       (state == S_COMPUTE),
      .addr     (pc),
      .data_out (inst)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         fetch_v <= 1'b0;
      end else begin
         fetch_v <= (state == S_COMPUTE);   // rom word next cycle
      end
   end

   assign dec_op  = opcode_e'(inst[31:29]);
   assign dec_tw  = inst[25:24];
   assign dec_rd  = inst[23:21];
   assign dec_ra  = inst[20:18];
   assign dec_rb  = inst[17:15];
   assign issue_v = fetch_v && (dec_op != OP_NOP);   // nops never reach the alu

   // output phase borrows read port a for r4..r7
   assign out_addr = reg_addr_t'(`LOAD_NUM + out_cnt);
   assign raddr_a  = (state == S_OUTPUT) ? out_addr : dec_ra;
   assign rf_re    = issue_v || (state == S_OUTPUT);

   twiddle_rom twiddle_rom_i (
      .clk      (clk),
      .en       (issue_v),
      .addr     (dec_tw),
      .data_out (tw_data)
   );

   // writeback wins only when no load is pending
   assign rf_we    = ld_v || wb_v;
   assign rf_waddr = ld_v ? ld_addr : rd_pipe[`ALU_LAT];
   assign rf_wdata = ld_v ? ld_data : wb_data;

   reg_file reg_file_i (
      .clk     (clk),
      .rst     (rst),
      .we      (rf_we),
      .waddr   (rf_waddr),
      .wdata   (rf_wdata),
      .re      (rf_re),
      .raddr_a (raddr_a),
      .raddr_b (dec_rb),
      .rdata_a (rdata_a),
      .rdata_b (rdata_b)
   );

   ////////////////////////////////////////
   // execute
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         alu_in_v <= 1'b0;
      end else begin
         alu_in_v <= issue_v;   // operands out of rf / rom now
      end
   end

   always_ff @(posedge clk) begin
      alu_op     <= dec_op;
      rd_pipe[0] <= dec_rd;
      for (int i = 1; i <= `ALU_LAT; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   complex_alu complex_alu_i (
      .clk    (clk),
      .rst    (rst),
      .in_v   (alu_in_v),
      .opcode (alu_op),
      .din_a  (rdata_a),
      .din_b  (rdata_b),
      .din_w  (tw_data),
      .dout_v (wb_v),
      .dout   (wb_data)
   );

   ////////////////////////////////////////
   // output burst
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         dout_v <= 1'b0;
      end else begin
         dout_v <= (state == S_OUTPUT);   // lines up with the rf read
      end
   end

   assign dout = rdata_a;

   // source spacing, no back-pressure here
   a_din_idle: assert property (@(posedge clk) disable iff (rst)
      din_v |-> (state == S_IDLE || state == S_LOAD))
      else $error("pe%0d: din_v while block in progress", STAGE);

   a_out_burst: assert property (@(posedge clk) disable iff (rst)
      $rose(dout_v) |-> ($past(state) == S_OUTPUT) ##0 dout_v [*`OUT_NUM] ##1 !dout_v)
      else $error("pe%0d: output burst malformed", STAGE);

   a_wr_clash: assert property (@(posedge clk) disable iff (rst)
      !(ld_v && wb_v))
      else $error("pe%0d: load write collides with writeback", STAGE);

endmodule

//--- rtl/complex_alu.sv
`include "fft_pe_defines.svh"

module complex_alu (
   input  logic                clk,
   input  logic                rst,
   input  logic                in_v,
   input  fft_pe_pkg::opcode_e opcode,
   input  fft_pe_pkg::cplx_t   din_a,
   input  fft_pe_pkg::cplx_t   din_b,
   input  fft_pe_pkg::cplx_t   din_w,
   output logic                dout_v,
   output fft_pe_pkg::cplx_t   dout
);
   import fft_pe_pkg::*;

   sample_t b_re, b_im, w_re, w_im;
   logic signed [2*`DATA_WIDTH-1:0] p_rr, p_ii, p_ri, p_ir;   // stage 1 products
   logic signed [2*`DATA_WIDTH:0]   mix_re, mix_im;           // one guard bit
   logic signed [2*`DATA_WIDTH:0]   shr_re, shr_im;
   sample_t wb_re, wb_im;                                     // stage 2, w*b
   sample_t a_re, a_im, res_re, res_im;
   cplx_t   a_s1, a_s2;                                       // a rides along
   opcode_e op_s1, op_s2;
   logic [`ALU_LAT-1:0] v_pipe;

   assign b_re = din_b[`WORD_WIDTH-1 -: `DATA_WIDTH];
   assign b_im = din_b[`DATA_WIDTH-1:0];
   assign w_re = din_w[`WORD_WIDTH-1 -: `DATA_WIDTH];
   assign w_im = din_w[`DATA_WIDTH-1:0];

   ////////////////////////////////////////
   // stage 1: partial products
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      p_rr  <= b_re * w_re;
      p_ii  <= b_im * w_im;
      p_ri  <= b_re * w_im;
      p_ir  <= b_im * w_re;
      a_s1  <= din_a;
      op_s1 <= opcode;
   end

   ////////////////////////////////////////
   // stage 2: combine and rescale
   ////////////////////////////////////////
   always_comb begin
      mix_re = p_rr - p_ii;
      mix_im = p_ri + p_ir;
      shr_re = mix_re >>> `TW_FRAC;   // back to integer scale
      shr_im = mix_im >>> `TW_FRAC;
   end

   always_ff @(posedge clk) begin
      wb_re <= shr_re[`DATA_WIDTH-1:0];   // magnitudes bounded, no overflow
      wb_im <= shr_im[`DATA_WIDTH-1:0];
      a_s2  <= a_s1;
      op_s2 <= op_s1;
   end

   ////////////////////////////////////////
   // stage 3: butterfly add / sub
   ////////////////////////////////////////
   assign a_re = a_s2[`WORD_WIDTH-1 -: `DATA_WIDTH];
   assign a_im = a_s2[`DATA_WIDTH-1:0];

   always_comb begin
      case (op_s2)
         OP_BFLY_ADD: begin
            res_re = a_re + wb_re;
            res_im = a_im + wb_im;
         end
         OP_BFLY_SUB: begin
            res_re = a_re - wb_re;
            res_im = a_im - wb_im;
         end
         default: begin   // nop passes a
            res_re = a_re;
            res_im = a_im;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      dout <= {res_re, res_im};
   end

   // valid follows the data, ALU_LAT deep
   always_ff @(posedge clk) begin
      if (rst) begin
         v_pipe <= '0;
      end else begin
         v_pipe <= {v_pipe[`ALU_LAT-2:0], in_v};
      end
   end

   assign dout_v = v_pipe[`ALU_LAT-1];

endmodule

//--- rtl/reg_file.sv
`include "fft_pe_defines.svh"

module reg_file (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  we,
   input  fft_pe_pkg::reg_addr_t waddr,
   input  fft_pe_pkg::cplx_t     wdata,
   input  logic                  re,
   input  fft_pe_pkg::reg_addr_t raddr_a,
   input  fft_pe_pkg::reg_addr_t raddr_b,
   output fft_pe_pkg::cplx_t     rdata_a,
   output fft_pe_pkg::cplx_t     rdata_b
);
   import fft_pe_pkg::*;

   cplx_t regs [`REG_NUM];

   ////////////////////////////////////////
   // write port
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `REG_NUM; i++) begin
            regs[i] <= '0;   // drop any partial block
         end
      end else if (we) begin
         regs[waddr] <= wdata;
      end
   end

   ////////////////////////////////////////
   // read ports
   ////////////////////////////////////////
   // both reads registered, old data on same-cycle write
   always_ff @(posedge clk) begin
      if (re) begin
         rdata_a <= regs[raddr_a];   // ra / output read
         rdata_b <= regs[raddr_b];   // rb operand
      end
   end

   a_waddr_known: assert property (@(posedge clk) disable iff (rst)
      we |-> !$isunknown(waddr))
      else $error("reg_file: write with unknown address");

endmodule

//--- rtl/twiddle_rom.sv
`include "fft_pe_defines.svh"

module twiddle_rom (
   input  logic                 clk,
   input  logic                 en,
   input  fft_pe_pkg::tw_addr_t addr,
   output fft_pe_pkg::cplx_t    data_out
);
   import fft_pe_pkg::*;

   localparam sample_t ONE  = sample_t'(1 << `TW_FRAC);   // 16384
   localparam sample_t ZERO = sample_t'(0);

   // W4^k = exp(-j*2*pi*k/4), {re, im}
   localparam cplx_t TW [`TW_NUM] = '{
      {ONE,  ZERO},    // 1
      {ZERO, -ONE},    // -j
      {-ONE, ZERO},    // -1
      {ZERO, ONE}      // +j
   };

   always_ff @(posedge clk) begin
      if (en) begin
         data_out <= TW[addr];
      end
   end

endmodule

//--- rtl/inst_rom.sv
`include "fft_pe_defines.svh"

module inst_rom #(
   parameter int STAGE = 0
) (
   input  logic                 clk,
   input  logic                 en,
   input  fft_pe_pkg::im_addr_t addr,
   output fft_pe_pkg::inst_t    data_out
);
   import fft_pe_pkg::*;

   ////////////////////////////////////////
   // stage programs
   ////////////////////////////////////////
   // stage 0: pairs (x0,x2) and (x1,x3), all with w0
   localparam inst_t PROG0 [`INST_NUM] = '{
      mk_inst(OP_BFLY_ADD, 2'd0, 3'd4, 3'd0, 3'd2),  // r4 = r0 + r2
      mk_inst(OP_BFLY_SUB, 2'd0, 3'd5, 3'd0, 3'd2),  // r5 = r0 - r2
      mk_inst(OP_BFLY_ADD, 2'd0, 3'd6, 3'd1, 3'd3),  // r6 = r1 + r3
      mk_inst(OP_BFLY_SUB, 2'd0, 3'd7, 3'd1, 3'd3)   // r7 = r1 - r3
   };

   // stage 1: odd branch gets w1 = -j, results land in X order
   localparam inst_t PROG1 [`INST_NUM] = '{
      mk_inst(OP_BFLY_ADD, 2'd0, 3'd4, 3'd0, 3'd2),  // X0
      mk_inst(OP_BFLY_ADD, 2'd1, 3'd5, 3'd1, 3'd3),  // X1
      mk_inst(OP_BFLY_SUB, 2'd0, 3'd6, 3'd0, 3'd2),  // X2
      mk_inst(OP_BFLY_SUB, 2'd1, 3'd7, 3'd1, 3'd3)   // X3
   };

   inst_t prog_word;

   assign prog_word = (STAGE == 0) ? PROG0[addr] : PROG1[addr];

   always_ff @(posedge clk) begin
      if (en) begin
         data_out <= prog_word;   // one cycle fetch
      end
   end

   // every fetched word decodes to a known op
   a_legal_op: assert property (@(posedge clk)
      en |=> data_out[31:29] inside {OP_NOP, OP_BFLY_ADD, OP_BFLY_SUB})
      else $error("inst_rom stage %0d: illegal opcode fetched", STAGE);

endmodule

//--- rtl/fft_pe_pkg.sv
`include "fft_pe_defines.svh"

package fft_pe_pkg;

   typedef logic signed [`DATA_WIDTH-1:0]    sample_t;   // one part
   typedef logic        [`WORD_WIDTH-1:0]    cplx_t;     // {re, im}
   typedef logic        [31:0]               inst_t;
   typedef logic        [`REG_ADDR_WIDTH-1:0] reg_addr_t;
   typedef logic        [`TW_ADDR_WIDTH-1:0]  tw_addr_t;
   typedef logic        [`IM_ADDR_WIDTH-1:0]  im_addr_t;

   typedef enum logic [2:0] {
      OP_NOP      = 3'd0,
      OP_BFLY_ADD = 3'd1,   // rd = ra + w*rb
      OP_BFLY_SUB = 3'd2    // rd = ra - w*rb
   } opcode_e;

   typedef enum logic [2:0] {
      S_IDLE,
      S_LOAD,
      S_COMPUTE,
      S_DRAIN,
      S_OUTPUT
   } pe_state_e;

   // pack one instruction word, unused bits stay zero
   function automatic inst_t mk_inst(opcode_e op, tw_addr_t tw, reg_addr_t rd,
                                     reg_addr_t ra, reg_addr_t rb);
      inst_t w;
      w        = '0;
      w[31:29] = op;
      w[25:24] = tw;   // twiddle index
      w[23:21] = rd;
      w[20:18] = ra;
      w[17:15] = rb;
      return w;
   endfunction

endpackage

//--- include/fft_pe_defines.svh
`ifndef FFT_PE_DEFINES_SVH
`define FFT_PE_DEFINES_SVH

////////////////////////////////////////
// data widths
////////////////////////////////////////
`define DATA_WIDTH     16           // one real or imag part
`define WORD_WIDTH     32           // complex word, real in upper half

////////////////////////////////////////
// storage sizes
////////////////////////////////////////
`define REG_NUM        8            // r0-r3 inputs, r4-r7 results
`define REG_ADDR_WIDTH 3
`define LOAD_NUM       4            // words per input block
`define INST_NUM       4            // butterflies per stage
`define IM_ADDR_WIDTH  2
`define TW_NUM         4            // W4^0 .. W4^3
`define TW_ADDR_WIDTH  2
`define TW_FRAC        14           // Q2.14, 1.0 = 16384

////////////////////////////////////////
// timing
////////////////////////////////////////
`define ALU_LAT        3            // complex alu pipe depth
`define OUT_NUM        4            // words per output burst
`define BLOCK_SPACING  20           // min cycles between block starts

`endif
